//--- exu_alu.f
+incdir+dv
source/exu_alu_pkg.sv
source/alu_adder_cmp.sv
source/alu_shifter.sv
source/alu_result_sel.sv
source/branch_resolve.sv
source/exu_alu.sv
dv/exu_alu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the exu_alu testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f exu_alu.f --top-module exu_alu_tb -o exu_alu_sim \
   && ./obj_dir/exu_alu_sim > sim.log 2>&1 \
   || echo "build or simulation returned an error"

[ -f sim.log ] && cat sim.log

grep -q "TEST PASSED" sim.log 2>/dev/null \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed"; exit 1; }

//--- dv/exu_alu_tests.svh
// directed tests, inputs change on the rising edge, outputs sampled on the falling edge

task automatic test_reset;
   // nothing strobed yet, all state still cleared
   @(negedge clk);
   check_xlen("result_ff", '0, result_ff);
   check_pc("pc_ff", '0, pc_ff);
   check_bit("flush_upper_out", 1'b0, flush_upper_out);
   check_bit("flush_final_out", 1'b0, flush_final_out);
   check_bit("pred_correct_out", 1'b0, pred_correct_out);
   check_bit("misp_out", 1'b0, misp_out);
   end_test("reset");
endtask

// strobe already driven, result shows one edge later
task automatic result_after_strobe(input exu_alu_pkg::xlen_t exp);
   @(posedge clk);
   set_idle();
   @(negedge clk);
   check_xlen("result_ff", exp, result_ff);
endtask

task automatic test_arith;
   int i;
   exu_alu_pkg::xlen_t a;
   exu_alu_pkg::xlen_t b;
   exu_alu_pkg::xlen_t exp;
   for (i = 0; i < 28; i++)
   begin
      a = $random(seed);
      b = $random(seed);
      @(posedge clk);
      set_idle();
      valid_in <= 1'b1;
      a_in <= a;
      b_in <= b;
      case (i % 7)
         0:
         begin
            op_add <= 1'b1;
            exp = a + b;
         end
         1:
         begin
            op_sub <= 1'b1;
            exp = a - b;
         end
         2:
         begin
            logic_op <= exu_alu_pkg::LOGIC_AND;
            exp = a & b;
         end
         3:
         begin
            logic_op <= exu_alu_pkg::LOGIC_OR;
            exp = a | b;
         end
         4:
         begin
            logic_op <= exu_alu_pkg::LOGIC_XOR;
            exp = a ^ b;
         end
         5:
         begin
            op_sub <= 1'b1;
            op_slt <= 1'b1;
            exp = {31'd0, $signed(a) < $signed(b)};
         end
         default:
         begin
            // sltu
            op_sub <= 1'b1;
            op_slt <= 1'b1;
            op_unsign <= 1'b1;
            exp = {31'd0, a < b};
         end
      endcase
      result_after_strobe(exp);
   end
   end_test("arith");
endtask

task automatic test_shifts;
   int i;
   logic [4:0] amt;
   exu_alu_pkg::xlen_t a;
   exu_alu_pkg::xlen_t exp;
   exu_alu_pkg::xlen_t prev_exp;
   prev_exp = '0;
   for (i = 0; i < 24; i++)
   begin
      a = $random(seed);
      // each shift type sees amount 0 and 31 first
      if (i < 3)
         amt = 5'd0;
      else if (i < 6)
         amt = 5'd31;
      else
         amt = 5'($random(seed));
      @(posedge clk);
      set_idle();
      valid_in <= 1'b1;
      a_in <= a;
      // upper bits of b are junk, only the low five count
      b_in <= {27'($random(seed)), amt};
      case (i % 3)
         0:
         begin
            shift_op <= exu_alu_pkg::SHIFT_SLL;
            exp = a << amt;
         end
         1:
         begin
            shift_op <= exu_alu_pkg::SHIFT_SRL;
            exp = a >> amt;
         end
         default:
         begin
            shift_op <= exu_alu_pkg::SHIFT_SRA;
            exp = exu_alu_pkg::xlen_t'($signed(a) >>> amt);
         end
      endcase
      // back to back, this edge captured the previous op
      if (i > 0)
      begin
         @(negedge clk);
         check_xlen("result_ff", prev_exp, result_ff);
      end
      prev_exp = exp;
   end
   result_after_strobe(prev_exp);
   end_test("shifts");
endtask

task automatic test_branches;
   int bi;
   int p;
   int h;
   exu_alu_pkg::branch_op_t br_ops [4];
   exu_alu_pkg::xlen_t a;
   exu_alu_pkg::xlen_t b;
   exu_alu_pkg::pc_t pc;
   exu_alu_pkg::broff_t off;
   logic pt;
   logic taken;
   logic exp_misp;
   br_ops[0] = exu_alu_pkg::BR_BEQ;
   br_ops[1] = exu_alu_pkg::BR_BNE;
   br_ops[2] = exu_alu_pkg::BR_BLT;
   br_ops[3] = exu_alu_pkg::BR_BGE;
   for (bi = 0; bi < 4; bi++)
      for (p = 0; p < 2; p++)
         for (h = 0; h < 4; h++)
         begin
            a = $random(seed);
            // even histories get equal operands
            if (h % 2 == 0)
               b = a;
            else
               b = $random(seed);
            pc = exu_alu_pkg::pc_t'($random(seed));
            off = exu_alu_pkg::broff_t'($random(seed));
            pt = (p == 1);
            @(posedge clk);
            set_idle();
            valid_in <= 1'b1;
            op_sub <= 1'b1;
            branch_op <= br_ops[bi];
            predict_t <= pt;
            predict_nt <= ~pt;
            hist_in <= exu_alu_pkg::hist_t'(h);
            a_in <= a;
            b_in <= b;
            pc_in <= pc;
            brimm_in <= off;
            taken = branch_taken(br_ops[bi], a, b);
            exp_misp = (pt & ~taken) | (~pt & taken);
            @(negedge clk);
            check_bit("ataken_out", taken, ataken_out);
            check_bit("misp_out", exp_misp, misp_out);
            check_bit("pred_correct_out", ~exp_misp, pred_correct_out);
            check_bit("flush_upper_out", exp_misp, flush_upper_out);
            check_bit("flush_final_out", exp_misp, flush_final_out);
            check_pc("flush_path_out", target_pc(pc, off), flush_path_out);
            check_hist("hist_out", next_hist(exu_alu_pkg::hist_t'(h), taken), hist_out);
         end
   end_test("branches");
endtask

task automatic test_jal;
   int i;
   exu_alu_pkg::xlen_t a;
   exu_alu_pkg::xlen_t b;
   exu_alu_pkg::xlen_t jsum;
   exu_alu_pkg::pc_t pc;
   exu_alu_pkg::broff_t off;
   for (i = 0; i < 6; i++)
   begin
      a = $random(seed);
      b = $random(seed);
      pc = exu_alu_pkg::pc_t'($random(seed));
      off = exu_alu_pkg::broff_t'($random(seed));
      // the adder adds with no op flag, so the sum select stays off
      @(posedge clk);
      set_idle();
      valid_in <= 1'b1;
      branch_op <= exu_alu_pkg::BR_JAL;
      a_in <= a;
      b_in <= b;
      pc_in <= pc;
      brimm_in <= off;
      jsum = a + b;
      @(negedge clk);
      check_pc("flush_path_out", jsum[31:1], flush_path_out);
      check_bit("pred_correct_out", 1'b0, pred_correct_out);
      check_bit("flush_upper_out", 1'b1, flush_upper_out);
      check_bit("flush_final_out", 1'b1, flush_final_out);
      check_bit("ataken_out", 1'b1, ataken_out);
      result_after_strobe({target_pc(pc, off), 1'b0});
   end
   end_test("jal");
endtask

task automatic test_flush_enable;
   exu_alu_pkg::xlen_t a;
   exu_alu_pkg::xlen_t b;
   exu_alu_pkg::xlen_t exp1;
   exu_alu_pkg::pc_t p1;
   exu_alu_pkg::pc_t p2;
   a = $random(seed);
   b = $random(seed);
   p1 = exu_alu_pkg::pc_t'($random(seed));
   p2 = exu_alu_pkg::pc_t'($random(seed));
   // older flush kills a jal
   @(posedge clk);
   set_idle();
   valid_in <= 1'b1;
   branch_op <= exu_alu_pkg::BR_JAL;
   flush_upper_x <= 1'b1;
   @(negedge clk);
   check_bit("flush_upper_out", 1'b0, flush_upper_out);
   check_bit("flush_final_out", 1'b0, flush_final_out);
   // beq with equal operands predicted not taken mispredicts
   @(posedge clk);
   set_idle();
   valid_in <= 1'b1;
   op_sub <= 1'b1;
   branch_op <= exu_alu_pkg::BR_BEQ;
   a_in <= a;
   b_in <= a;
   predict_nt <= 1'b1;
   flush_upper_x <= 1'b1;
   @(negedge clk);
   check_bit("flush_upper_out", 1'b0, flush_upper_out);
   check_bit("flush_final_out", 1'b0, flush_final_out);
   check_bit("misp_out", 1'b0, misp_out);
   // same mispredict under a lower flush
   @(posedge clk);
   flush_upper_x <= 1'b0;
   flush_lower_r <= 1'b1;
   @(negedge clk);
   check_bit("flush_upper_out", 1'b0, flush_upper_out);
   check_bit("flush_final_out", 1'b1, flush_final_out);
   check_bit("misp_out", 1'b0, misp_out);
   // lower flush on a bubble
   @(posedge clk);
   set_idle();
   flush_lower_r <= 1'b1;
   @(negedge clk);
   check_bit("flush_upper_out", 1'b0, flush_upper_out);
   check_bit("flush_final_out", 1'b1, flush_final_out);
   // load result and pc once, then hold them with enable low
   @(posedge clk);
   set_idle();
   valid_in <= 1'b1;
   logic_op <= exu_alu_pkg::LOGIC_OR;
   a_in <= a;
   b_in <= b;
   pc_in <= p1;
   exp1 = a | b;
   @(posedge clk);
   set_idle();
   enable <= 1'b0;
   valid_in <= 1'b1;
   logic_op <= exu_alu_pkg::LOGIC_XOR;
   a_in <= ~a;
   pc_in <= p2;
   @(negedge clk);
   check_xlen("result_ff", exp1, result_ff);
   check_pc("pc_ff", p1, pc_ff);
   @(posedge clk);
   @(negedge clk);
   check_xlen("result_ff", exp1, result_ff);
   check_pc("pc_ff", p1, pc_ff);
   // enable back, bubble keeps result, pc follows pc_in on the next edge
   @(posedge clk);
   set_idle();
   @(posedge clk);
   @(negedge clk);
   check_xlen("result_ff", exp1, result_ff);
   check_pc("pc_ff", p2, pc_ff);
   end_test("flush_enable");
endtask

//--- dv/exu_alu_tb.sv
`default_nettype none
`timescale 1ns/1ns

module exu_alu_tb;

   logic clk;
   logic rst;
   logic enable;
   logic valid_in;
   logic flush_upper_x;
   logic flush_lower_r;
   logic op_add;
   logic op_sub;
   logic op_unsign;
   logic op_slt;
   exu_alu_pkg::logic_op_t logic_op;
   exu_alu_pkg::shift_op_t shift_op;
   exu_alu_pkg::branch_op_t branch_op;
   logic predict_t;
   logic predict_nt;
   exu_alu_pkg::hist_t hist_in;
   exu_alu_pkg::xlen_t a_in;
   exu_alu_pkg::xlen_t b_in;
   exu_alu_pkg::pc_t pc_in;
   exu_alu_pkg::broff_t brimm_in;
   exu_alu_pkg::xlen_t result_ff;
   exu_alu_pkg::pc_t pc_ff;
   logic flush_upper_out;
   logic flush_final_out;
   exu_alu_pkg::pc_t flush_path_out;
   logic pred_correct_out;
   logic misp_out;
   logic ataken_out;
   exu_alu_pkg::hist_t hist_out;

   // random stream for operands, pcs and offsets
   int seed;
   int check_count;
   int error_count;
   // error count when the running test started
   int test_err_base;
   bit released;

   exu_alu dut (.*);

   // 8 ns clock
   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_xlen(input string name, input exu_alu_pkg::xlen_t exp,
                             input exu_alu_pkg::xlen_t act);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("CHECK FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_pc(input string name, input exu_alu_pkg::pc_t exp,
                           input exu_alu_pkg::pc_t act);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("CHECK FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_hist(input string name, input exu_alu_pkg::hist_t exp,
                             input exu_alu_pkg::hist_t act);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("CHECK FAILED time %0t %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("CHECK FAILED time %0t %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   // branch outcome straight from the instruction semantics
   function automatic logic branch_taken(input exu_alu_pkg::branch_op_t op,
                                         input exu_alu_pkg::xlen_t a,
                                         input exu_alu_pkg::xlen_t b);
      case (op)
         exu_alu_pkg::BR_BEQ: return (a == b);
         exu_alu_pkg::BR_BNE: return (a != b);
         exu_alu_pkg::BR_BLT: return ($signed(a) < $signed(b));
         exu_alu_pkg::BR_BGE: return ($signed(a) >= $signed(b));
         exu_alu_pkg::BR_JAL: return 1'b1;
         default:             return 1'b0;
      endcase
   endfunction

   // history table, one row per old value
   function automatic exu_alu_pkg::hist_t next_hist(input exu_alu_pkg::hist_t old,
                                                    input logic taken);
      case (old)
         2'b00:   return taken ? 2'b10 : 2'b01;
         2'b01:   return taken ? 2'b00 : 2'b01;
         2'b10:   return taken ? 2'b11 : 2'b00;
         default: return taken ? 2'b11 : 2'b10;
      endcase
   endfunction

   // pc plus sign extended offset, both without bit 0
   function automatic exu_alu_pkg::pc_t target_pc(input exu_alu_pkg::pc_t pc,
                                                  input exu_alu_pkg::broff_t off);
      return pc + {{19{off[12]}}, off};
   endfunction

   // all controls back to a bubble, operands and pc keep their values
   task automatic set_idle;
      enable <= 1'b1;
      valid_in <= 1'b0;
      flush_upper_x <= 1'b0;
      flush_lower_r <= 1'b0;
      op_add <= 1'b0;
      op_sub <= 1'b0;
      op_unsign <= 1'b0;
      op_slt <= 1'b0;
      logic_op <= exu_alu_pkg::LOGIC_NONE;
      shift_op <= exu_alu_pkg::SHIFT_NONE;
      branch_op <= exu_alu_pkg::BR_NONE;
      predict_t <= 1'b0;
      predict_nt <= 1'b0;
   endtask

   task automatic end_test(input string name);
      $display("test %s finished with %0d errors", name, error_count - test_err_base);
      test_err_base = error_count;
   endtask

   task automatic wait_reset_release(output bit ok);
      int cycles;
      cycles = 0;
      while (rst !== 1'b0 && cycles < 10)
      begin
         @(posedge clk);
         cycles++;
      end
      ok = (rst === 1'b0);
   endtask

   initial
   begin
      seed = 32'he8da_a0b0;
      check_count = 0;
      error_count = 0;
      test_err_base = 0;
      rst = 1'b1;
      // flops stay at their reset value until the first op
      enable = 1'b0;
      valid_in = 1'b0;
      flush_upper_x = 1'b0;
      flush_lower_r = 1'b0;
      op_add = 1'b0;
      op_sub = 1'b0;
      op_unsign = 1'b0;
      op_slt = 1'b0;
      logic_op = exu_alu_pkg::LOGIC_NONE;
      shift_op = exu_alu_pkg::SHIFT_NONE;
      branch_op = exu_alu_pkg::BR_NONE;
      predict_t = 1'b0;
      predict_nt = 1'b0;
      hist_in = '0;
      a_in = '0;
      b_in = '0;
      pc_in = '0;
      brimm_in = '0;
      // three reset edges seen by the dut
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      wait_reset_release(released);
      if (!released)
      begin
         $display("reset was still asserted 10 cycles after its release");
         $display("TEST FAILED");
      end
      else
      begin
         test_reset();
         test_arith();
         test_shifts();
         test_branches();
         test_jal();
         test_flush_enable();
         $display("checks run %0d, errors %0d", check_count, error_count);
         if (error_count == 0)
            $display("TEST PASSED");
         else
            $display("TEST FAILED");
      end
      $finish;
   end

   `include "exu_alu_tests.svh"

endmodule

`default_nettype wire

//--- source/exu_alu.sv
`default_nettype none
`timescale 1ns/1ns

module exu_alu
(
   input  logic                       clk,
   input  logic                       rst,
   // clock enable for the result and pc flops
   input  logic                       enable,
   // single cycle strobe, one op per cycle
   input  logic                       valid_in,
   // branch flush from the previous cycle
   input  logic                       flush_upper_x,
   // flush of the whole pipe
   input  logic                       flush_lower_r,
   input  logic                       op_add,
   input  logic                       op_sub,
   input  logic                       op_unsign,
   input  logic                       op_slt,
   input  exu_alu_pkg::logic_op_t     logic_op,
   input  exu_alu_pkg::shift_op_t     shift_op,
   input  exu_alu_pkg::branch_op_t    branch_op,
   input  logic                       predict_t,
   input  logic                       predict_nt,
   input  exu_alu_pkg::hist_t         hist_in,
   input  exu_alu_pkg::xlen_t         a_in,
   // immediates are already muxed in here
   input  exu_alu_pkg::xlen_t         b_in,
   input  exu_alu_pkg::pc_t           pc_in,
   input  exu_alu_pkg::broff_t        brimm_in,
   output exu_alu_pkg::xlen_t         result_ff,
   output exu_alu_pkg::pc_t           pc_ff,
   output logic                       flush_upper_out,
   output logic                       flush_final_out,
   output exu_alu_pkg::pc_t           flush_path_out,
   output logic                       pred_correct_out,
   output logic                       misp_out,
   output logic                       ataken_out,
   output exu_alu_pkg::hist_t         hist_out
);

   // adder and compare results, shared by alu and branch
   exu_alu_pkg::xlen_t sum;
   logic lt;
   logic eq;
   exu_alu_pkg::xlen_t shift_out;
   // pc plus offset, jal link address
   exu_alu_pkg::pc_t link_pc;

   alu_adder_cmp u_adder_cmp
   (
      .a_in      (a_in),
      .b_in      (b_in),
      .op_sub    (op_sub),
      .op_unsign (op_unsign),
      .sum       (sum),
      .lt        (lt),
      .eq        (eq)
   );

   // only the low bits of b carry the shift amount
   alu_shifter u_shifter
   (
      .a_in      (a_in),
      .shamt     (b_in[exu_alu_pkg::SHAMT_W-1:0]),
      .shift_op  (shift_op),
      .shift_out (shift_out)
   );

   alu_result_sel u_result_sel
   (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .valid_in  (valid_in),
      .a_in      (a_in),
      .b_in      (b_in),
      .logic_op  (logic_op),
      .shift_op  (shift_op),
      .op_add    (op_add),
      .op_sub    (op_sub),
      .op_slt    (op_slt),
      .branch_op (branch_op),
      .sum       (sum),
      .lt        (lt),
      .shift_out (shift_out),
      .link_pc   (link_pc),
      .result_ff (result_ff)
   );

   branch_resolve u_branch_resolve
   (
      .clk              (clk),
      .rst              (rst),
      .enable           (enable),
      .valid_in         (valid_in),
      .flush_upper_x    (flush_upper_x),
      .flush_lower_r    (flush_lower_r),
      .branch_op        (branch_op),
      .predict_t        (predict_t),
      .predict_nt       (predict_nt),
      .hist_in          (hist_in),
      .pc_in            (pc_in),
      .brimm_in         (brimm_in),
      .sum              (sum),
      .lt               (lt),
      .eq               (eq),
      .link_pc          (link_pc),
      .pc_ff            (pc_ff),
      .flush_upper_out  (flush_upper_out),
      .flush_final_out  (flush_final_out),
      .flush_path_out   (flush_path_out),
      .pred_correct_out (pred_correct_out),
      .misp_out         (misp_out),
      .ataken_out       (ataken_out),
      .hist_out         (hist_out)
   );

endmodule

`default_nettype wire

//--- source/branch_resolve.sv
`default_nettype none
`timescale 1ns/1ns

module branch_resolve
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   input  logic                       valid_in,
   input  logic                       flush_upper_x,
   input  logic                       flush_lower_r,
   input  exu_alu_pkg::branch_op_t    branch_op,
   input  logic                       predict_t,
   input  logic                       predict_nt,
   input  exu_alu_pkg::hist_t         hist_in,
   input  exu_alu_pkg::pc_t           pc_in,
   input  exu_alu_pkg::broff_t        brimm_in,
   input  exu_alu_pkg::xlen_t         sum,
   input  logic                       lt,
   input  logic                       eq,
   output exu_alu_pkg::pc_t           link_pc,
   output exu_alu_pkg::pc_t           pc_ff,
   output logic                       flush_upper_out,
   output logic                       flush_final_out,
   output exu_alu_pkg::pc_t           flush_path_out,
   output logic                       pred_correct_out,
   output logic                       misp_out,
   output logic                       ataken_out,
   output exu_alu_pkg::hist_t         hist_out
);

   // offset sign extended to pc width
   exu_alu_pkg::pc_t brimm_sext;
   logic any_jal;
   logic actual_taken;
   logic cond_mispredict;
   // jal or mispredict that survives the older flush
   logic flush_cause;

   // any pc passes through here, not only branches
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc_ff <= '0;
      end
      else if (enable)
      begin
         pc_ff <= pc_in;
      end
   end

   assign brimm_sext = {{(exu_alu_pkg::PC_W-exu_alu_pkg::BROFF_W){brimm_in[exu_alu_pkg::BROFF_W]}},
                        brimm_in};

   // for a conditional branch this is the path opposite the prediction
   // for jal it is the return address
   assign link_pc = pc_in + brimm_sext;

   assign any_jal = (branch_op == exu_alu_pkg::BR_JAL);

   always_comb
   begin
      case (branch_op)
         exu_alu_pkg::BR_BEQ: actual_taken = eq;
         exu_alu_pkg::BR_BNE: actual_taken = ~eq;
         exu_alu_pkg::BR_BLT: actual_taken = lt;
         exu_alu_pkg::BR_BGE: actual_taken = ~lt;
         exu_alu_pkg::BR_JAL: actual_taken = 1'b1;
         default:             actual_taken = 1'b0;
      endcase
   end

   assign cond_mispredict = (predict_t & ~actual_taken) |
                            (predict_nt & actual_taken);

   // tells the npc logic the flush path is not needed
   // jal always redirects, so never correct
   assign pred_correct_out = valid_in & ~any_jal &
                             ((predict_nt & ~actual_taken) | (predict_t & actual_taken));

   // jal target comes from the adder
   assign flush_path_out = any_jal ? sum[exu_alu_pkg::XLEN-1:1] : link_pc;

   // an older flush from x kills this op
   assign flush_cause = valid_in & (any_jal | cond_mispredict) & ~flush_upper_x;

   assign flush_upper_out = flush_cause & ~flush_lower_r;

   // lower flush wipes the whole pipe regardless of this op
   assign flush_final_out = flush_cause | flush_lower_r;

   assign misp_out = cond_mispredict & ~flush_upper_x & ~flush_lower_r;

   assign ataken_out = actual_taken;

   // history update, old history and taken in, new history out
   //   00: nt->01  t->10
   //   01: nt->01  t->00
   //   10: nt->00  t->11
   //   11: nt->10  t->11
   assign hist_out[1] = (hist_in[1] & hist_in[0]) | (~hist_in[0] & actual_taken);
   assign hist_out[0] = (~hist_in[1] & ~actual_taken) | (hist_in[1] & actual_taken);

   // the predictor sends one direction at most
   a_pred_excl: assert property (@(posedge clk) disable iff (rst)
      !(predict_t && predict_nt))
      else $error("branch_resolve: predict_t and predict_nt both set");

   // equal operands on beq or bne leave a zero difference in the adder
   a_eq_zero_diff: assert property (@(posedge clk) disable iff (rst)
      (valid_in && eq &&
       (branch_op == exu_alu_pkg::BR_BEQ || branch_op == exu_alu_pkg::BR_BNE))
      |-> (sum == '0))
      else $error("branch_resolve: equal compare without a zero difference");

endmodule

`default_nettype wire

//--- source/alu_result_sel.sv
`default_nettype none
`timescale 1ns/1ns

module alu_result_sel
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   input  logic                       valid_in,
   input  exu_alu_pkg::xlen_t         a_in,
   input  exu_alu_pkg::xlen_t         b_in,
   input  exu_alu_pkg::logic_op_t     logic_op,
   input  exu_alu_pkg::shift_op_t     shift_op,
   input  logic                       op_add,
   input  logic                       op_sub,
   input  logic                       op_slt,
   input  exu_alu_pkg::branch_op_t    branch_op,
   input  exu_alu_pkg::xlen_t         sum,
   input  logic                       lt,
   input  exu_alu_pkg::xlen_t         shift_out,
   input  exu_alu_pkg::pc_t           link_pc,
   output exu_alu_pkg::xlen_t         result_ff
);

   // logic unit output, zero when no logic op
   exu_alu_pkg::xlen_t lout;
   // combined result before the flop
   exu_alu_pkg::xlen_t result;
   logic sel_logic;
   logic sel_shift;
   logic sel_adder;
   logic sel_pc;
   logic slt_one;

   always_comb
   begin
      case (logic_op)
         exu_alu_pkg::LOGIC_AND: lout = a_in & b_in;
         exu_alu_pkg::LOGIC_OR:  lout = a_in | b_in;
         exu_alu_pkg::LOGIC_XOR: lout = a_in ^ b_in;
         default:                lout = '0;
      endcase
   end

   assign sel_logic = (logic_op != exu_alu_pkg::LOGIC_NONE);
   assign sel_shift = (shift_op != exu_alu_pkg::SHIFT_NONE);

   // slt also drives the adder as a subtract, keep the difference out
   assign sel_adder = (op_add | op_sub) & ~op_slt;

   // jal writes the link address to rd
   assign sel_pc = (branch_op == exu_alu_pkg::BR_JAL);

   // slt and sltu produce a single bit
   assign slt_one = op_slt & lt;

   // unselected terms are zero, so a plain or picks the result
   assign result = lout |
                   ({exu_alu_pkg::XLEN{sel_shift}} & shift_out) |
                   ({exu_alu_pkg::XLEN{sel_adder}} & sum) |
                   ({exu_alu_pkg::XLEN{sel_pc}} & {link_pc, 1'b0}) |
                   {{(exu_alu_pkg::XLEN-1){1'b0}}, slt_one};

   // result flop, loads only on a valid op
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         result_ff <= '0;
      end
      else if (enable && valid_in)
      begin
         result_ff <= result;
      end
   end

   // decode must never ask for two results at once
   a_one_sel: assert property (@(posedge clk) disable iff (rst)
      valid_in |-> $onehot0({sel_logic, sel_shift, sel_adder, sel_pc}))
      else $error("alu_result_sel: more than one result select active");

endmodule

`default_nettype wire

//--- source/alu_shifter.sv
`default_nettype none
`timescale 1ns/1ns

module alu_shifter
(
   input  exu_alu_pkg::xlen_t                    a_in,
   input  logic [exu_alu_pkg::SHAMT_W-1:0]       shamt,
   input  exu_alu_pkg::shift_op_t                shift_op,
   output exu_alu_pkg::xlen_t                    shift_out
);

   // right shift amount after the sll conversion
   logic [exu_alu_pkg::SHAMT_W-1:0] shift_amount;
   // clears the low bits that wrap around on sll
   exu_alu_pkg::xlen_t shift_mask;
   // a with 31 extra bits on top
   logic [2*exu_alu_pkg::XLEN-2:0] shift_extend;
   // low word of the shifted value
   exu_alu_pkg::xlen_t shift_long;
   logic is_sll;
   logic is_sra;

   assign is_sll = (shift_op == exu_alu_pkg::SHIFT_SLL);
   assign is_sra = (shift_op == exu_alu_pkg::SHIFT_SRA);

   // sll becomes a right shift by 32 - shamt
   // the 6th bit of 32 - shamt drops out, so shamt 0 stays 0
   always_comb
   begin
      if (is_sll)
         shift_amount = exu_alu_pkg::SHAMT_W'(6'd32 - {1'b0, shamt});
      else
         shift_amount = shamt;
   end

   // only sll needs the mask, everything else keeps all bits
   assign shift_mask = {exu_alu_pkg::XLEN{1'b1}} << (is_sll ? shamt : '0);

   assign shift_extend[exu_alu_pkg::XLEN-1:0] = a_in;

   // upper part is sign fill for sra, a low bits for sll, zero for srl
   assign shift_extend[2*exu_alu_pkg::XLEN-2:exu_alu_pkg::XLEN] =
      ({(exu_alu_pkg::XLEN-1){is_sra}} & {(exu_alu_pkg::XLEN-1){a_in[exu_alu_pkg::XLEN-1]}}) |
      ({(exu_alu_pkg::XLEN-1){is_sll}} & a_in[exu_alu_pkg::XLEN-2:0]);

   // one funnel shift serves all three ops
   assign shift_long = exu_alu_pkg::XLEN'(shift_extend >> shift_amount);

   assign shift_out = shift_long & shift_mask;

endmodule

`default_nettype wire

//--- source/alu_adder_cmp.sv
`default_nettype none
`timescale 1ns/1ns

module alu_adder_cmp
(
   input  exu_alu_pkg::xlen_t a_in,
   input  exu_alu_pkg::xlen_t b_in,
   input  logic               op_sub,
   input  logic               op_unsign,
   output exu_alu_pkg::xlen_t sum,
   output logic               lt,
   output logic               eq
);

   // b after optional inversion for subtract
   exu_alu_pkg::xlen_t bm;
   // carry out of the msb
   logic cout;
   // signed overflow
   logic ov;
   // sign of the sum
   logic neg;

   // sub is a + ~b + 1, the +1 rides in as carry in
   assign bm = op_sub ? ~b_in : b_in;

   assign {cout, sum} = {1'b0, a_in} + {1'b0, bm} + {{exu_alu_pkg::XLEN{1'b0}}, op_sub};

   assign neg = sum[exu_alu_pkg::XLEN-1];

   // operands same sign but sum sign flipped
   assign ov = (~a_in[exu_alu_pkg::XLEN-1] & ~bm[exu_alu_pkg::XLEN-1] & neg) |
               ( a_in[exu_alu_pkg::XLEN-1] &  bm[exu_alu_pkg::XLEN-1] & ~neg);

   // signed: true sign of a-b, unsigned: borrow out
   assign lt = (~op_unsign & (neg ^ ov)) |
               ( op_unsign & ~cout);

   // equality straight off the operands, no adder delay
   assign eq = (a_in == b_in);

   // a compare is only meaningful on subtract
   // equal operands give a zero difference with carry set, never less-than
   always_comb
   begin
      a_eq_not_lt: assert final (!(op_sub && eq && lt))
         else $error("alu_adder_cmp: eq and lt both set on a compare");
   end

endmodule

`default_nettype wire

//--- source/exu_alu_pkg.sv
`default_nettype none

package exu_alu_pkg;

   // data path width
   localparam int XLEN = 32;

   // pc is halfword aligned, bit 0 is never stored
   localparam int PC_W = XLEN - 1;

   // branch offset bits 12 down to 1
   localparam int BROFF_W = 12;

   // shift amount for a 32 bit operand
   localparam int SHAMT_W = 5;

   // 2-bit saturating-ish prediction history
   localparam int HIST_W = 2;

   // operand or result word
   typedef logic [XLEN-1:0] xlen_t;

   // pc without bit 0
   typedef logic [XLEN-1:1] pc_t;

   // branch offset without bit 0, bit 12 is the sign
   typedef logic [BROFF_W:1] broff_t;

   // history carried with the prediction
   typedef logic [HIST_W-1:0] hist_t;

   // logic unit controls, lui runs as an or with x0
   typedef enum logic [1:0] {
      LOGIC_NONE = 2'd0,
      LOGIC_XOR  = 2'd1,
      LOGIC_OR   = 2'd2,
      LOGIC_AND  = 2'd3
   } logic_op_t;

   // shifter controls
   typedef enum logic [1:0] {
      SHIFT_NONE = 2'd0,
      SHIFT_SRA  = 2'd1,
      SHIFT_SRL  = 2'd2,
      SHIFT_SLL  = 2'd3
   } shift_op_t;

   // branch controls, conditional branches also set sub for the compare
   typedef enum logic [2:0] {
      BR_NONE = 3'd0,
      BR_BGE  = 3'd1,
      BR_BLT  = 3'd2,
      BR_BNE  = 3'd3,
      BR_BEQ  = 3'd4,
      BR_JAL  = 3'd5
   } branch_op_t;

endpackage

`default_nettype wire
